// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int word_size = 16;

    typedef logic [1:0] reg_index_t;

    typedef enum logic [3:0] {
        op_adi   = 4'd4,
        op_lhi   = 4'd6,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_rtype = 4'd15
    } opcode_t;

    typedef enum logic [5:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_wwd = 6'd28,
        fn_hlt = 6'd29
    } func_t;

    // order follows the low func bits.
    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or
    } alu_op_t;

    typedef enum logic [1:0] {
        b_reg,
        b_simm,
        b_hi,
        b_zero
    } b_select_t;

    typedef struct packed {
        logic                 valid;
        logic [word_size-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                 valid;
        alu_op_t              alu_op;
        b_select_t            b_select;
        logic [word_size-1:0] rs_data;
        logic [word_size-1:0] rt_data;
        reg_index_t           rs;
        reg_index_t           rt;
        logic [7:0]           imm;
        reg_index_t           dest;
        logic                 mem_read;
        logic                 mem_write;
        logic                 reg_write;
        logic                 mem_to_reg;
        logic                 is_wwd;
        logic                 is_halt;
    } id_ex_t;

    typedef struct packed {
        logic                 valid;
        logic [word_size-1:0] alu_result;
        logic [word_size-1:0] store_data;
        reg_index_t           dest;
        logic                 mem_read;
        logic                 mem_write;
        logic                 reg_write;
        logic                 mem_to_reg;
        logic                 is_wwd;
        logic                 is_halt;
    } ex_mem_t;

    typedef struct packed {
        logic                 valid;
        logic [word_size-1:0] write_data;
        reg_index_t           dest;
        logic                 reg_write;
        logic                 is_halt;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: hw/stage_reg.sv
`default_nettype none

module stage_reg #(
    parameter type payload_t = cpu_pkg::if_id_t
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     stall,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            q <= '0;
        end else if (stall) begin
            q <= q;  // hold wins over bubble.
        end else if (bubble) begin
            q <= '0;  // valid and flags cleared.
        end else begin
            q <= d;
        end
    end

    valid_known: assert property (@(posedge clk) disable iff (reset_n)
        !$isunknown(q.valid));

endmodule

`default_nettype wire

// File: hw/decode_unit.sv
`default_nettype none

module decode_unit (
    input  logic [cpu_pkg::word_size-1:0] instr,
    output cpu_pkg::alu_op_t              alu_op,
    output cpu_pkg::b_select_t            b_select,
    output cpu_pkg::reg_index_t           rs,
    output cpu_pkg::reg_index_t           rt,
    output logic [7:0]                    imm,
    output cpu_pkg::reg_index_t           dest,
    output logic                          uses_rs,
    output logic                          uses_rt,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          reg_write,
    output logic                          mem_to_reg,
    output logic                          is_wwd,
    output logic                          is_halt
);

    assign rs  = instr[11:10];
    assign rt  = instr[9:8];
    assign imm = instr[7:0];

    always_comb begin
        alu_op     = cpu_pkg::alu_add;
        b_select   = cpu_pkg::b_reg;
        dest       = '0;
        uses_rs    = 1'b0;
        uses_rt    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        is_wwd     = 1'b0;
        is_halt    = 1'b0;
        case (cpu_pkg::opcode_t'(instr[15:12]))
            cpu_pkg::op_rtype: begin
                case (cpu_pkg::func_t'(instr[5:0]))
                    cpu_pkg::fn_add, cpu_pkg::fn_sub, cpu_pkg::fn_and, cpu_pkg::fn_orr: begin
                        alu_op    = cpu_pkg::alu_op_t'(instr[1:0]);
                        uses_rs   = 1'b1;
                        uses_rt   = 1'b1;
                        reg_write = 1'b1;
                        dest      = instr[7:6];  // rd.
                    end
                    cpu_pkg::fn_wwd: begin
                        b_select = cpu_pkg::b_zero;  // rs passes through.
                        uses_rs  = 1'b1;
                        is_wwd   = 1'b1;
                    end
                    cpu_pkg::fn_hlt: is_halt = 1'b1;
                    default: ;
                endcase
            end
            cpu_pkg::op_adi: begin
                b_select  = cpu_pkg::b_simm;
                uses_rs   = 1'b1;
                reg_write = 1'b1;
                dest      = rt;
            end
            cpu_pkg::op_lhi: begin
                b_select  = cpu_pkg::b_hi;
                reg_write = 1'b1;
                dest      = rt;
            end
            cpu_pkg::op_lwd: begin
                b_select   = cpu_pkg::b_simm;
                uses_rs    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
                dest       = rt;
            end
            cpu_pkg::op_swd: begin
                b_select  = cpu_pkg::b_simm;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;  // store data.
                mem_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          reset_n,
    input  cpu_pkg::reg_index_t           rs,
    input  cpu_pkg::reg_index_t           rt,
    output logic [cpu_pkg::word_size-1:0] rs_data,
    output logic [cpu_pkg::word_size-1:0] rt_data,
    input  logic                          write_en,
    input  cpu_pkg::reg_index_t           write_index,
    input  logic [cpu_pkg::word_size-1:0] write_data
);

    logic [cpu_pkg::word_size-1:0] regs [4];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_index] <= write_data;
        end
    end

    // same-cycle write bypasses to the read.
    assign rs_data = (write_en && write_index == rs) ? write_data : regs[rs];
    assign rt_data = (write_en && write_index == rt) ? write_data : regs[rt];

endmodule

`default_nettype wire

// File: hw/execute_unit.sv
`default_nettype none

module execute_unit (
    input  cpu_pkg::id_ex_t               id_ex,
    input  cpu_pkg::reg_index_t           ex_mem_dest,
    input  logic                          ex_mem_reg_write,
    input  logic [cpu_pkg::word_size-1:0] ex_mem_result,
    input  cpu_pkg::reg_index_t           wb_dest,
    input  logic                          wb_reg_write,
    input  logic [cpu_pkg::word_size-1:0] wb_data,
    output logic [cpu_pkg::word_size-1:0] alu_result,
    output logic [cpu_pkg::word_size-1:0] store_data
);

    localparam int w = cpu_pkg::word_size;

    logic [w-1:0] rs_fwd;
    logic [w-1:0] rt_fwd;
    logic [w-1:0] a;
    logic [w-1:0] b;

    // ex/mem checked last so the youngest wins.
    always_comb begin
        rs_fwd = id_ex.rs_data;
        rt_fwd = id_ex.rt_data;
        if (wb_reg_write && wb_dest == id_ex.rs) rs_fwd = wb_data;
        if (wb_reg_write && wb_dest == id_ex.rt) rt_fwd = wb_data;
        if (ex_mem_reg_write && ex_mem_dest == id_ex.rs) rs_fwd = ex_mem_result;
        if (ex_mem_reg_write && ex_mem_dest == id_ex.rt) rt_fwd = ex_mem_result;
    end

    assign store_data = rt_fwd;

    always_comb begin
        a = rs_fwd;
        case (id_ex.b_select)
            cpu_pkg::b_reg:  b = rt_fwd;
            cpu_pkg::b_simm: b = {{(w-8){id_ex.imm[7]}}, id_ex.imm};
            cpu_pkg::b_hi: begin
                a = '0;  // lhi ignores rs.
                b = w'({id_ex.imm, 8'h00});
            end
            default: b = '0;
        endcase
    end

    always_comb begin
        case (id_ex.alu_op)
            cpu_pkg::alu_add: alu_result = a + b;
            cpu_pkg::alu_sub: alu_result = a - b;
            cpu_pkg::alu_and: alu_result = a & b;
            default:          alu_result = a | b;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/hazard_unit.sv
`default_nettype none

module hazard_unit (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                id_ex_mem_read,
    input  cpu_pkg::reg_index_t id_ex_dest,
    input  cpu_pkg::reg_index_t rs,
    input  cpu_pkg::reg_index_t rt,
    input  logic                uses_rs,
    input  logic                uses_rt,
    input  logic                is_wwd,
    input  logic                is_halt,
    input  logic                if_id_valid,
    input  logic                has_credit,
    output logic                front_stall,
    output logic                wwd_issue,
    output logic                halt_fetch
);

    logic load_use;
    logic credit_wait;
    logic halt_seen;

    assign load_use = if_id_valid && id_ex_mem_read &&
                      ((uses_rs && rs == id_ex_dest) || (uses_rt && rt == id_ex_dest));
    assign credit_wait = if_id_valid && is_wwd && !has_credit;
    assign front_stall = load_use || credit_wait;
    assign wwd_issue   = if_id_valid && is_wwd && !front_stall;
    assign halt_fetch  = halt_seen || (if_id_valid && is_halt);  // hlt never stalls.

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_seen <= 1'b0;
        end else if (if_id_valid && is_halt) begin
            halt_seen <= 1'b1;
        end
    end

    // the bubble behind a load clears the hazard.
    single_bubble: assert property (@(posedge clk) disable iff (reset_n)
        load_use |=> !load_use);

endmodule

`default_nettype wire

// File: hw/data_mem.sv
`default_nettype none

module data_mem #(
    parameter int dmem_depth = 64
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic [cpu_pkg::word_size-1:0] address,
    input  logic [cpu_pkg::word_size-1:0] write_data,
    output logic [cpu_pkg::word_size-1:0] read_data
);

    localparam int aw = $clog2(dmem_depth);

    logic [cpu_pkg::word_size-1:0] mem [dmem_depth];
    logic [aw-1:0]                 index;

    assign index = aw'(address % dmem_depth);  // wraps.

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < dmem_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_write) begin
            mem[index] <= write_data;
        end
    end

    assign read_data = mem_read ? mem[index] : '0;

endmodule

`default_nettype wire

// File: hw/wwd_credit_port.sv
`default_nettype none

module wwd_credit_port #(
    parameter int wwd_credits = 4
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          wwd_issue,
    input  logic                          send,
    input  logic [cpu_pkg::word_size-1:0] send_data,
    input  logic                          credit_return,
    output logic                          has_credit,
    output logic                          wwd_valid,
    output logic [cpu_pkg::word_size-1:0] wwd_data
);

    localparam int cw = $clog2(wwd_credits + 1);

    logic [cw-1:0] count;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            count     <= cw'(wwd_credits);
            wwd_valid <= 1'b0;
        end else begin
            case ({wwd_issue, credit_return})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: ;  // both or neither.
            endcase
            wwd_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        wwd_data <= send_data;
    end

    assign has_credit = (count != '0);

    no_overflow: assert property (@(posedge clk) disable iff (reset_n)
        count <= cw'(wwd_credits));

    no_underflow: assert property (@(posedge clk) disable iff (reset_n)
        wwd_issue |-> count != '0);

endmodule

`default_nettype wire

// File: hw/pipeline_cpu.sv
`default_nettype none

module pipeline_cpu #(
    parameter int dmem_depth  = 64,
    parameter int wwd_credits = 4
) (
    input  logic                          clk,
    input  logic                          reset_n,
    output logic [cpu_pkg::word_size-1:0] pc,
    input  logic [cpu_pkg::word_size-1:0] instr,
    output logic                          wwd_valid,
    output logic [cpu_pkg::word_size-1:0] wwd_data,
    input  logic                          credit_return,
    output logic                          halted
);

    localparam int w = cpu_pkg::word_size;

    cpu_pkg::if_id_t     if_id_d;
    cpu_pkg::if_id_t     if_id_q;
    cpu_pkg::id_ex_t     id_ex_d;
    cpu_pkg::id_ex_t     id_ex_q;
    cpu_pkg::ex_mem_t    ex_mem_d;
    cpu_pkg::ex_mem_t    ex_mem_q;
    cpu_pkg::mem_wb_t    mem_wb_d;
    cpu_pkg::mem_wb_t    mem_wb_q;

    cpu_pkg::alu_op_t    alu_op;
    cpu_pkg::b_select_t  b_select;
    cpu_pkg::reg_index_t rs;
    cpu_pkg::reg_index_t rt;
    cpu_pkg::reg_index_t dest;
    logic [7:0]          imm;
    logic                uses_rs;
    logic                uses_rt;
    logic                mem_read;
    logic                mem_write;
    logic                reg_write;
    logic                mem_to_reg;
    logic                is_wwd;
    logic                is_halt;
    logic [w-1:0]        rs_data;
    logic [w-1:0]        rt_data;
    logic [w-1:0]        alu_result;
    logic [w-1:0]        store_data;
    logic [w-1:0]        read_data;
    logic                front_stall;
    logic                wwd_issue;
    logic                halt_fetch;
    logic                has_credit;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc <= '0;
        end else if (!front_stall && !halt_fetch) begin
            pc <= pc + 1'b1;
        end
    end

    assign if_id_d = '{valid: 1'b1, instr: instr};

    stage_reg #(.payload_t(cpu_pkg::if_id_t)) if_id_reg (
        .clk(clk), .reset_n(reset_n), .stall(front_stall), .bubble(halt_fetch),
        .d(if_id_d), .q(if_id_q)
    );

    decode_unit decoder (
        .instr(if_id_q.instr), .alu_op(alu_op), .b_select(b_select), .rs(rs), .rt(rt),
        .imm(imm), .dest(dest), .uses_rs(uses_rs), .uses_rt(uses_rt), .mem_read(mem_read),
        .mem_write(mem_write), .reg_write(reg_write), .mem_to_reg(mem_to_reg),
        .is_wwd(is_wwd), .is_halt(is_halt)
    );

    reg_file regs (
        .clk(clk), .reset_n(reset_n), .rs(rs), .rt(rt), .rs_data(rs_data), .rt_data(rt_data),
        .write_en(mem_wb_q.reg_write), .write_index(mem_wb_q.dest),
        .write_data(mem_wb_q.write_data)
    );

    hazard_unit hazards (
        .clk(clk), .reset_n(reset_n), .id_ex_mem_read(id_ex_q.mem_read),
        .id_ex_dest(id_ex_q.dest), .rs(rs), .rt(rt), .uses_rs(uses_rs), .uses_rt(uses_rt),
        .is_wwd(is_wwd), .is_halt(is_halt), .if_id_valid(if_id_q.valid),
        .has_credit(has_credit), .front_stall(front_stall), .wwd_issue(wwd_issue),
        .halt_fetch(halt_fetch)
    );

    assign id_ex_d = '{
        valid: if_id_q.valid, alu_op: alu_op, b_select: b_select,
        rs_data: rs_data, rt_data: rt_data, rs: rs, rt: rt, imm: imm, dest: dest,
        mem_read: mem_read, mem_write: mem_write, reg_write: reg_write,
        mem_to_reg: mem_to_reg, is_wwd: is_wwd, is_halt: is_halt
    };

    // stalled instruction stays in if/id, a bubble goes on.
    stage_reg #(.payload_t(cpu_pkg::id_ex_t)) id_ex_reg (
        .clk(clk), .reset_n(reset_n), .stall(1'b0), .bubble(front_stall),
        .d(id_ex_d), .q(id_ex_q)
    );

    execute_unit alu (
        .id_ex(id_ex_q), .ex_mem_dest(ex_mem_q.dest), .ex_mem_reg_write(ex_mem_q.reg_write),
        .ex_mem_result(ex_mem_q.alu_result), .wb_dest(mem_wb_q.dest),
        .wb_reg_write(mem_wb_q.reg_write), .wb_data(mem_wb_q.write_data),
        .alu_result(alu_result), .store_data(store_data)
    );

    assign ex_mem_d = '{
        valid: id_ex_q.valid, alu_result: alu_result, store_data: store_data,
        dest: id_ex_q.dest, mem_read: id_ex_q.mem_read, mem_write: id_ex_q.mem_write,
        reg_write: id_ex_q.reg_write, mem_to_reg: id_ex_q.mem_to_reg,
        is_wwd: id_ex_q.is_wwd, is_halt: id_ex_q.is_halt
    };

    stage_reg #(.payload_t(cpu_pkg::ex_mem_t)) ex_mem_reg (
        .clk(clk), .reset_n(reset_n), .stall(1'b0), .bubble(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    data_mem #(.dmem_depth(dmem_depth)) dmem (
        .clk(clk), .reset_n(reset_n), .mem_read(ex_mem_q.mem_read),
        .mem_write(ex_mem_q.mem_write), .address(ex_mem_q.alu_result),
        .write_data(ex_mem_q.store_data), .read_data(read_data)
    );

    assign mem_wb_d = '{
        valid: ex_mem_q.valid,
        write_data: ex_mem_q.mem_to_reg ? read_data : ex_mem_q.alu_result,
        dest: ex_mem_q.dest, reg_write: ex_mem_q.reg_write, is_halt: ex_mem_q.is_halt
    };

    stage_reg #(.payload_t(cpu_pkg::mem_wb_t)) mem_wb_reg (
        .clk(clk), .reset_n(reset_n), .stall(1'b0), .bubble(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halted <= 1'b0;
        end else if (mem_wb_q.valid && mem_wb_q.is_halt) begin
            halted <= 1'b1;  // sticky until reset.
        end
    end

    wwd_credit_port #(.wwd_credits(wwd_credits)) wwd_port (
        .clk(clk), .reset_n(reset_n), .wwd_issue(wwd_issue),
        .send(ex_mem_q.valid && ex_mem_q.is_wwd), .send_data(ex_mem_q.alu_result),
        .credit_return(credit_return), .has_credit(has_credit),
        .wwd_valid(wwd_valid), .wwd_data(wwd_data)
    );

endmodule

`default_nettype wire

// File: verification/cpu_tb.sv
`default_nettype none

module cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int w            = cpu_pkg::word_size;
    localparam int dmem_depth   = 64;
    localparam int wwd_credits  = 4;
    localparam int num_programs = 6;
    localparam int max_len      = 80;
    localparam int clk_period   = 40;

    logic         clk;
    logic         reset_n;
    logic [w-1:0] pc;
    logic [w-1:0] instr;
    logic         wwd_valid;
    logic [w-1:0] wwd_data;
    logic         credit_return = 1'b0;
    logic         halted;

    logic [w-1:0] prog_mem [num_programs*max_len];
    int           prog_len [num_programs];
    int           exp_end [num_programs];  // cumulative wwd count per program.
    logic [w-1:0] expected_words [$];
    int           return_due [$];

    logic [w-1:0] model_regs [4];
    logic [w-1:0] model_mem [dmem_depth];

    int     cur_prog;
    int     cur_base;
    int     cycle_count;
    int     received_count;
    int     valid_count;
    int     returned_count;
    int     min_delay;
    int     max_delay;
    longint watchdog_cycles;

    pipeline_cpu #(.dmem_depth(dmem_depth), .wwd_credits(wwd_credits)) UUT (
        .clk(clk), .reset_n(reset_n), .pc(pc), .instr(instr),
        .wwd_valid(wwd_valid), .wwd_data(wwd_data),
        .credit_return(credit_return), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // combinational fetch port.
    always_comb begin
        if (pc < w'(prog_len[cur_prog])) begin
            instr = prog_mem[cur_base + int'(pc)];
        end else begin
            instr = '0;
        end
    end

    // consumer hands credits back once their delay has run out.
    always @(posedge clk) begin
        cycle_count++;
        if (return_due.size() != 0 && return_due[0] <= cycle_count) begin
            void'(return_due.pop_front());
            returned_count++;
            credit_return <= 1'b1;
        end else begin
            credit_return <= 1'b0;
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [w-1:0] actual,
                              input logic [w-1:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("ERR %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("ERR %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    function automatic logic [w-1:0] encode_rtype(input cpu_pkg::reg_index_t rs,
                                                  input cpu_pkg::reg_index_t rt,
                                                  input cpu_pkg::reg_index_t rd,
                                                  input logic [5:0] fn);
        return {4'(cpu_pkg::op_rtype), rs, rt, rd, fn};
    endfunction

    function automatic logic [w-1:0] encode_itype(input logic [3:0] op,
                                                  input cpu_pkg::reg_index_t rs,
                                                  input cpu_pkg::reg_index_t rt,
                                                  input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic void reset_model();
        for (int i = 0; i < 4; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < dmem_depth; i++) begin
            model_mem[i] = '0;
        end
    endfunction

    // sequential isa reference.
    function automatic void run_model(input logic [w-1:0] ins);
        cpu_pkg::reg_index_t rs;
        cpu_pkg::reg_index_t rt;
        cpu_pkg::reg_index_t rd;
        logic [w-1:0]        a;
        logic [w-1:0]        b;
        logic [w-1:0]        sum;
        int                  addr;
        rs   = ins[11:10];
        rt   = ins[9:8];
        rd   = ins[7:6];
        a    = model_regs[rs];
        b    = model_regs[rt];
        sum  = a + {{(w-8){ins[7]}}, ins[7:0]};
        addr = int'(sum) % dmem_depth;
        case (ins[15:12])
            4'(cpu_pkg::op_rtype): begin
                case (ins[5:0])
                    6'(cpu_pkg::fn_add): model_regs[rd] = a + b;
                    6'(cpu_pkg::fn_sub): model_regs[rd] = a - b;
                    6'(cpu_pkg::fn_and): model_regs[rd] = a & b;
                    6'(cpu_pkg::fn_orr): model_regs[rd] = a | b;
                    6'(cpu_pkg::fn_wwd): expected_words.push_back(a);
                    default: ;
                endcase
            end
            4'(cpu_pkg::op_adi): model_regs[rt] = sum;
            4'(cpu_pkg::op_lhi): model_regs[rt] = w'({ins[7:0], 8'h00});
            4'(cpu_pkg::op_lwd): model_regs[rt] = model_mem[addr];
            4'(cpu_pkg::op_swd): model_mem[addr] = b;
            default: ;
        endcase
    endfunction

    // mostly lands on addresses 0 to 3 so loads meet earlier stores.
    function automatic logic [7:0] memory_offset(input cpu_pkg::reg_index_t rs);
        logic [w-1:0] off;
        if ($urandom_range(0, 3) == 0) begin
            return 8'($urandom());
        end
        off = w'($urandom_range(0, 3)) - model_regs[rs];
        return {2'($urandom_range(0, 3)), off[5:0]};
    endfunction

    task automatic generate_program(input int p);
        int                  len;
        int                  base;
        int                  kind;
        logic                load_pending;
        cpu_pkg::reg_index_t load_dest;
        cpu_pkg::reg_index_t rs;
        cpu_pkg::reg_index_t rt;
        cpu_pkg::reg_index_t rd;
        logic [w-1:0]        ins;
        len          = $urandom_range(40, max_len);
        base         = p * max_len;
        load_pending = 1'b0;
        load_dest    = '0;
        reset_model();
        for (int i = 0; i < len - 1; i++) begin
            rs   = 2'($urandom());
            rt   = 2'($urandom());
            rd   = 2'($urandom());
            kind = $urandom_range(0, 9);
            if (load_pending && $urandom_range(0, 1) == 1) begin
                if (kind < 5) begin
                    ins = encode_rtype(load_dest, rt, rd, 6'(cpu_pkg::fn_wwd));
                end else begin
                    ins = encode_rtype(rs, load_dest, rd, 6'(cpu_pkg::fn_sub));
                end
            end else begin
                case (kind)
                    0, 1, 2: ins = encode_rtype(rs, rt, rd, 6'($urandom_range(0, 3)));
                    3: ins = encode_itype(4'(cpu_pkg::op_adi), rs, rt, 8'($urandom()));
                    4: ins = encode_itype(4'(cpu_pkg::op_lhi), rs, rt, 8'($urandom()));
                    5: ins = encode_itype(4'(cpu_pkg::op_lwd), rs, rt, memory_offset(rs));
                    6: ins = encode_itype(4'(cpu_pkg::op_swd), rs, rt, memory_offset(rs));
                    default: ins = encode_rtype(rs, rt, rd, 6'(cpu_pkg::fn_wwd));
                endcase
            end
            load_pending = (ins[15:12] == 4'(cpu_pkg::op_lwd));
            load_dest    = ins[9:8];
            prog_mem[base + i] = ins;
            run_model(ins);
        end
        prog_mem[base + len - 1] = encode_rtype(2'd0, 2'd0, 2'd0, 6'(cpu_pkg::fn_hlt));
        prog_len[p] = len;
        exp_end[p]  = expected_words.size();
    endtask

    // one cycle of output monitoring at the falling edge.
    task automatic sample_cycle();
        @(negedge clk);
        if (wwd_valid) begin
            if (received_count >= exp_end[cur_prog]) begin
                report_failure("wwd_valid pulsed with no expected WWD word left");
            end
            check_word("wwd_data", wwd_data, expected_words[received_count]);
            received_count++;
            valid_count++;
            return_due.push_back(cycle_count + int'($urandom_range(min_delay, max_delay)));
            if (valid_count - returned_count > wwd_credits) begin
                report_failure("more WWD words outstanding than the credit limit allows");
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_n <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) begin
                reset_n <= 1'b0;
            end
            @(negedge clk);
            check_word("pc", pc, '0);
            check_flag("wwd_valid", wwd_valid, 1'b0);
            check_flag("halted", halted, 1'b0);
        end
    endtask

    task automatic run_program(input int p);
        sample_cycle();
        while (!halted) begin
            sample_cycle();
        end
        if (received_count != exp_end[p]) begin
            report_failure("halted rose before every expected WWD word arrived");
        end
        repeat (12) begin
            sample_cycle();
            check_flag("halted", halted, 1'b1);
            check_flag("wwd_valid", wwd_valid, 1'b0);
            check_word("pc", pc, w'(prog_len[p]));  // fetch froze just past the hlt.
        end
        while (return_due.size() != 0) begin
            sample_cycle();  // let the consumer drain.
        end
    endtask

    initial begin : watchdog
        wait (watchdog_cycles != 0);
        #(watchdog_cycles * clk_period);
        report_failure("timeout: the programs did not finish within the cycle budget");
    end

    initial begin : main
        longint total_len;
        reset_n    = 1'b1;
        total_len  = 0;
        void'($urandom(32'h7c85_a650));
        for (int p = 0; p < num_programs; p++) begin
            generate_program(p);
            total_len += prog_len[p];
        end
        watchdog_cycles = total_len * 30;
        for (int p = 0; p < num_programs; p++) begin
            cur_prog = p;
            cur_base = p * max_len;
            if (p % 2 == 1) begin
                min_delay = 40;  // credits held back.
                max_delay = 80;
            end else begin
                min_delay = 1;
                max_delay = 6;
            end
            apply_reset();
            run_program(p);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/cpu_pkg.sv
hw/stage_reg.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/hazard_unit.sv
hw/data_mem.sv
hw/wwd_credit_port.sv
hw/pipeline_cpu.sv
verification/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
